// File: heapMemory.f
+incdir+sim
rtl/heapPkg.sv
rtl/requestQueue.sv
rtl/arrayAllocator.sv
rtl/arrayStore.sv
rtl/heapController.sv
rtl/heapTop.sv
sim/heapTb.sv

// File: rtl/arrayAllocator.sv
`timescale 1ns/100ps
/*
  Array number bookkeeping. Offers the most recently freed array first, then
  the next never-used number, and keeps one allocated flag per array.
*/
module arrayAllocator import heapPkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  logic    allocTake,                          // Granted number is used
  input  logic    freeTake,                           // freeArray goes back to the pool
  input  arrayNum freeArray,
  input  arrayNum queryArray,                         // Array whose flag is reported
  output logic    allocAvail,                         // Some array can be allocated
  output arrayNum allocArray,                         // Number an alloc would get
  output logic    isAllocated                         // Flag of queryArray
);

  logic [arrayCount-1:0]       allocated;             // One flag per array
  arrayNum                     freeStack [arrayCount];// Freed numbers, newest on top
  logic [$clog2(arrayCount):0] stackDepth;            // Entries in freeStack
  logic [$clog2(arrayCount):0] freshCount;            // Numbers handed out so far
  arrayNum                     stackTopArray;

  //--------------------------------------------------------------------------
  // Offer
  //--------------------------------------------------------------------------
  assign stackTopArray = freeStack[arrayNum'(stackDepth - 1'b1)];
  assign allocAvail    = (stackDepth != '0) || (freshCount < arrayCount);
  assign allocArray    = (stackDepth != '0) ? stackTopArray   // Reuse first
                                            : arrayNum'(freshCount);
  assign isAllocated   = allocated[queryArray];

  //--------------------------------------------------------------------------
  // Update
  //--------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      allocated  <= '0;                               // Nothing allocated
      stackDepth <= '0;
      freshCount <= '0;                               // Start handing out from 0
    end else if (allocTake) begin
      allocated[allocArray] <= 1'b1;
      if (stackDepth != '0) stackDepth <= stackDepth - 1'b1;   // Pop reused number
      else freshCount <= freshCount + 1'b1;
    end else if (freeTake) begin
      allocated[freeArray] <= 1'b0;
      stackDepth <= stackDepth + 1'b1;
    end
  end

  // Free number onto the stack, depth stays below arrayCount while any is allocated
  always_ff @(posedge clock) begin
    if (freeTake && !allocTake) begin
      freeStack[arrayNum'(stackDepth)] <= freeArray;
    end
  end

endmodule

// File: rtl/arrayStore.sv
`timescale 1ns/100ps
/*
  Element registers and per-array sizes. Applies one enabled update per
  cycle and shows the size and element of the addressed array at once.
  All legality checks are made by the controller.
*/
module arrayStore import heapPkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     storeEnable,                       // Apply storeOp this cycle
  input  heapOp    storeOp,
  input  arrayNum  storeArray,
  input  elemIndex storeIndex,
  input  heapData  storeData,
  output arraySize size,                              // Size of storeArray
  output heapData  element                            // storeArray[storeIndex]
);

  heapData  memory [arrayCount][arrayLength];         // Fixed block per array
  arraySize sizes  [arrayCount];

  assign size    = sizes[storeArray];
  assign element = memory[storeArray][storeIndex];    // Pre-update value

  //--------------------------------------------------------------------------
  // Element updates
  //--------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (storeEnable) begin
      case (storeOp)
        opWrite: memory[storeArray][storeIndex] <= storeData;
        opPush:  memory[storeArray][elemIndex'(size)] <= storeData;  // Lands at the size
        opUp: begin
          // Shift index..size-1 up by one, then place the new value
          for (int i = 1; i < arrayLength; i++) begin
            if (i > storeIndex && i <= size) begin
              memory[storeArray][i] <= memory[storeArray][i-1];
            end
          end
          memory[storeArray][storeIndex] <= storeData;
        end
        opDown: begin
          for (int i = 0; i < arrayLength - 1; i++) begin
            if (i >= storeIndex && i + 1 < size) begin   // Close the gap
              memory[storeArray][i] <= memory[storeArray][i+1];
            end
          end
        end
        default: ;                                    // Reads leave elements alone
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // Size updates
  //--------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < arrayCount; a++) begin
        sizes[a] <= '0;
      end
    end else if (storeEnable) begin
      case (storeOp)
        opAlloc: sizes[storeArray] <= '0;             // Fresh array is empty
        opWrite: begin
          if (arraySize'(storeIndex) >= size) begin   // Grow to cover the index
            sizes[storeArray] <= arraySize'(storeIndex) + 1'b1;
          end
        end
        opPush, opUp:  sizes[storeArray] <= size + 1'b1;
        opPop, opDown: sizes[storeArray] <= size - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// File: rtl/heapController.sv
`timescale 1ns/100ps
/*
  Request decoder of the heap. Takes the queue head every cycle it is valid,
  checks it against allocator and store state, commands the update and
  registers the response, which appears on the following cycle.
*/
module heapController import heapPkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         headValid,
  input  heapOp        headOp,
  input  arrayNum      headArray,
  input  elemIndex     headIndex,
  input  heapData      headData,
  input  arraySize     size,                          // From store, addressed array
  input  heapData      element,
  input  logic         allocAvail,
  input  arrayNum      allocArray,
  input  logic         isAllocated,                   // Flag of headArray
  output logic         headTake,
  output logic         storeEnable,
  output heapOp        storeOp,
  output arrayNum      storeArray,
  output elemIndex     storeIndex,
  output heapData      storeData,
  output logic         allocTake,
  output logic         freeTake,
  output arrayNum      freeArray,
  output logic         rspValid,
  output heapData      rspData,
  output heapErrorCode rspError
);

  logic         isFull;                               // No room for one more
  logic         isEmpty;
  logic         atOrPastSize;                         // Index not holding an element
  logic         pastSize;                             // Index beyond insert range
  logic         requestOk;
  heapErrorCode nextError;
  heapData      nextData;

  assign isFull       = size == arraySize'(arrayLength);
  assign isEmpty      = size == '0;
  assign atOrPastSize = arraySize'(headIndex) >= size;
  assign pastSize     = arraySize'(headIndex) > size;

  //--------------------------------------------------------------------------
  // Checks and response value
  //--------------------------------------------------------------------------
  always_comb begin
    nextError = errNone;
    nextData  = '0;                                   // Zero unless the op returns data
    if (headOp != opAlloc && !isAllocated) begin
      nextError = errNotAllocated;                    // Checked before anything else
    end else begin
      case (headOp)
        opAlloc: begin
          if (!allocAvail) nextError = errOutOfMemory;
          else nextData = heapData'(allocArray);
        end
        opWrite: nextData = headData;                 // Echo written value
        opRead: begin
          if (atOrPastSize) nextError = errOutOfBounds;
          else nextData = element;
        end
        opSize: nextData = heapData'(size);
        opPush: if (isFull) nextError = errFull;
        opPop: begin
          if (isEmpty) nextError = errEmpty;
          else nextData = element;                    // Top element, see storeIndex
        end
        opUp: begin
          if (pastSize) nextError = errOutOfBounds;
          else if (isFull) nextError = errFull;
        end
        opDown: begin
          if (isEmpty) nextError = errEmpty;
          else if (atOrPastSize) nextError = errOutOfBounds;
          else nextData = element;                    // Removed element
        end
        default: ;                                    // Free and unknown ops
      endcase
    end
  end

  assign requestOk = nextError == errNone;

  //--------------------------------------------------------------------------
  // Commands, all state changes land at the end of this cycle
  //--------------------------------------------------------------------------
  assign headTake    = headValid;                     // One request per cycle
  assign storeEnable = headValid && requestOk;
  assign storeOp     = headOp;
  assign storeArray  = (headOp == opAlloc) ? allocArray : headArray;
  assign storeIndex  = (headOp == opPop) ? elemIndex'(size - 1'b1) : headIndex;
  assign storeData   = headData;
  assign allocTake   = headValid && requestOk && headOp == opAlloc;
  assign freeTake    = headValid && requestOk && headOp == opFree;
  assign freeArray   = headArray;

  // Response register
  always_ff @(posedge clock) begin
    if (reset) rspValid <= 1'b0;
    else rspValid <= headValid;
  end

  always_ff @(posedge clock) begin
    if (headValid) begin
      rspData  <= nextData;
      rspError <= nextError;
    end
  end

endmodule

// File: rtl/heapPkg.sv
/*
  Shared sizes, request encodings and data types of the heap memory.
  Every RTL block and the testbench import this package with a wildcard.
*/
package heapPkg;

  //--------------------------------------------------------------------------
  // Sizes
  //--------------------------------------------------------------------------
  localparam int arrayCount  = 4;                     // Arrays in the pool
  localparam int arrayLength = 4;                     // Max elements per array
  localparam int dataBits    = 12;                    // Element width
  localparam int queueDepth  = 2;                     // Request slots, also initial credits

  //--------------------------------------------------------------------------
  // Types
  //--------------------------------------------------------------------------
  typedef logic [$clog2(arrayCount)-1:0]  arrayNum;   // Array number
  typedef logic [$clog2(arrayLength)-1:0] elemIndex;  // Element index in an array
  typedef logic [$clog2(arrayLength):0]   arraySize;  // 0 to arrayLength
  typedef logic [dataBits-1:0]            heapData;   // Element and response data

  // Request operations
  typedef enum logic [3:0] {
    opAlloc = 4'd0,                                   // New array, returns its number
    opFree  = 4'd1,                                   // Release an array
    opWrite = 4'd2,                                   // Store element, may grow size
    opRead  = 4'd3,                                   // Fetch element
    opSize  = 4'd4,                                   // Current size
    opPush  = 4'd5,                                   // Append at the size
    opPop   = 4'd6,                                   // Remove last element
    opUp    = 4'd7,                                   // Insert at index
    opDown  = 4'd8                                    // Remove at index
  } heapOp;

  // Response error codes
  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                           // Array never allocated or freed
    errOutOfBounds  = 3'd2,                           // Index past the size
    errFull         = 3'd3,                           // No room to grow
    errEmpty        = 3'd4,                           // Nothing to take
    errOutOfMemory  = 3'd5                            // No array left to allocate
  } heapErrorCode;

endpackage

// File: rtl/heapTop.sv
`timescale 1ns/100ps
/*
  Heap memory top level. Requests enter the credit-bounded queue, the
  controller serves one per cycle and returns one response each, in order.
*/
module heapTop import heapPkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         reqValid,                      // Only while holding a credit
  input  heapOp        reqOp,
  input  arrayNum      reqArray,
  input  elemIndex     reqIndex,
  input  heapData      reqData,
  output logic         creditReturn,
  output logic         rspValid,
  output heapData      rspData,
  output heapErrorCode rspError
);

  logic     headValid, headTake;                      // Queue head handshake
  heapOp    headOp;
  arrayNum  headArray;
  elemIndex headIndex;
  heapData  headData;
  logic     storeEnable;                              // Controller to store
  heapOp    storeOp;
  arrayNum  storeArray;
  elemIndex storeIndex;
  heapData  storeData;
  arraySize size;                                     // Store back to controller
  heapData  element;
  logic     allocTake, freeTake, allocAvail, isAllocated;
  arrayNum  freeArray, allocArray;

  requestQueue u_requestQueue (
    .clock, .reset, .reqValid, .reqOp, .reqArray, .reqIndex, .reqData,
    .headTake, .headValid, .headOp, .headArray, .headIndex, .headData, .creditReturn
  );

  heapController u_heapController (
    .clock, .reset, .headValid, .headOp, .headArray, .headIndex, .headData,
    .size, .element, .allocAvail, .allocArray, .isAllocated, .headTake,
    .storeEnable, .storeOp, .storeArray, .storeIndex, .storeData,
    .allocTake, .freeTake, .freeArray, .rspValid, .rspData, .rspError
  );

  arrayAllocator u_arrayAllocator (
    .clock, .reset, .allocTake, .freeTake, .freeArray,
    .queryArray (headArray),                          // Flag of the head request
    .allocAvail, .allocArray, .isAllocated
  );

  arrayStore u_arrayStore (
    .clock, .reset, .storeEnable, .storeOp, .storeArray, .storeIndex, .storeData,
    .size, .element
  );

endmodule

// File: rtl/requestQueue.sv
`timescale 1ns/100ps
/*
  Small request FIFO in front of the heap controller. The sender is bounded by
  credits, so no full check is made; one credit returns per dequeued request.
*/
module requestQueue import heapPkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     reqValid,                          // One request per pulse
  input  heapOp    reqOp,
  input  arrayNum  reqArray,
  input  elemIndex reqIndex,
  input  heapData  reqData,
  input  logic     headTake,                          // Controller dequeues the head
  output logic     headValid,
  output heapOp    headOp,
  output arrayNum  headArray,
  output elemIndex headIndex,
  output heapData  headData,
  output logic     creditReturn                       // One cycle per dequeue
);

  heapOp    opSlot    [queueDepth];                   // Request payload slots
  arrayNum  arraySlot [queueDepth];
  elemIndex indexSlot [queueDepth];
  heapData  dataSlot  [queueDepth];

  logic [$clog2(queueDepth)-1:0] wrPtr;               // Next free slot
  logic [$clog2(queueDepth)-1:0] rdPtr;               // Head slot
  logic [$clog2(queueDepth):0]   count;               // Occupied slots

  // Payload write, credits guarantee a free slot
  always_ff @(posedge clock) begin
    if (reqValid) begin
      opSlot[wrPtr]    <= reqOp;
      arraySlot[wrPtr] <= reqArray;
      indexSlot[wrPtr] <= reqIndex;
      dataSlot[wrPtr]  <= reqData;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wrPtr        <= '0;
      rdPtr        <= '0;
      count        <= '0;
      creditReturn <= 1'b0;
    end else begin
      if (reqValid) wrPtr <= wrPtr + 1'b1;            // Wraps at queueDepth
      if (headTake) rdPtr <= rdPtr + 1'b1;
      case ({reqValid, headTake})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                      // Both or neither
      endcase
      creditReturn <= headTake;                       // Credit back a cycle later
    end
  end

  assign headValid = count != '0;
  assign headOp    = opSlot[rdPtr];
  assign headArray = arraySlot[rdPtr];
  assign headIndex = indexSlot[rdPtr];
  assign headData  = dataSlot[rdPtr];

endmodule

// File: sim/heapModel.svh
/*
  Reference model of the heap memory, included into the testbench module.
  heapModel applies one request to the model state and gives the response.
*/
`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

logic    modelAllocated [arrayCount];                 // Allocated flag per array
int      modelSizes     [arrayCount];
heapData modelMemory    [arrayCount][arrayLength];    // Kept across free and alloc
arrayNum modelFreed     [$];                          // Freed numbers, newest last
int      modelFresh;                                  // Next never-used number

function automatic void modelReset();
  for (int a = 0; a < arrayCount; a++) begin
    modelAllocated[a] = 1'b0;
    modelSizes[a]     = 0;
  end
  modelFreed.delete();
  modelFresh = 0;
endfunction

function automatic void heapModel(input heapOp op, input arrayNum arr, input elemIndex idx,
                                  input heapData data, output heapData rspData,
                                  output heapErrorCode rspError);
  int size;
  int a;
  size     = modelSizes[arr];
  rspData  = '0;
  rspError = errNone;
  if (op != opAlloc && !modelAllocated[arr]) begin
    rspError = errNotAllocated;                       // Wins over every other error
    return;
  end
  case (op)
    opAlloc: begin
      if (modelFreed.size() != 0) begin
        a = modelFreed.pop_back();                    // Most recently freed first
      end else if (modelFresh < arrayCount) begin
        a = modelFresh;
        modelFresh++;
      end else begin
        rspError = errOutOfMemory;
        return;
      end
      modelAllocated[a] = 1'b1;
      modelSizes[a]     = 0;
      rspData           = heapData'(a);
    end
    opFree: begin
      modelAllocated[arr] = 1'b0;
      modelFreed.push_back(arr);
    end
    opWrite: begin
      modelMemory[arr][idx] = data;
      if (idx >= size) modelSizes[arr] = idx + 1;     // Grow to cover the index
      rspData = data;
    end
    opRead: begin
      if (idx >= size) rspError = errOutOfBounds;
      else rspData = modelMemory[arr][idx];
    end
    opSize: rspData = heapData'(size);
    opPush: begin
      if (size == arrayLength) begin
        rspError = errFull;
      end else begin
        modelMemory[arr][size] = data;
        modelSizes[arr] = size + 1;
      end
    end
    opPop: begin
      if (size == 0) begin
        rspError = errEmpty;
      end else begin
        rspData = modelMemory[arr][size-1];
        modelSizes[arr] = size - 1;
      end
    end
    opUp: begin
      if (idx > size) begin
        rspError = errOutOfBounds;
      end else if (size == arrayLength) begin
        rspError = errFull;
      end else begin
        for (int i = size; i > idx; i--) modelMemory[arr][i] = modelMemory[arr][i-1];
        modelMemory[arr][idx] = data;
        modelSizes[arr] = size + 1;
      end
    end
    opDown: begin
      // Empty array reported ahead of the bounds check
      if (size == 0) begin
        rspError = errEmpty;
      end else if (idx >= size) begin
        rspError = errOutOfBounds;
      end else begin
        rspData = modelMemory[arr][idx];
        for (int i = idx; i < size - 1; i++) modelMemory[arr][i] = modelMemory[arr][i+1];
        modelSizes[arr] = size - 1;
      end
    end
    default: ;
  endcase
endfunction

`endif

// File: sim/heapTb.sv
`timescale 1ns/100ps
/*
  Testbench of the heap memory. Sends directed and random requests on credits,
  predicts each response with the reference model and checks them in order.
*/
module heapTb import heapPkg::*; ();

  logic         clock;
  logic         reset;
  logic         reqValid;
  heapOp        reqOp;
  arrayNum      reqArray;
  elemIndex     reqIndex;
  heapData      reqData;
  logic         creditReturn;
  logic         rspValid;
  heapData      rspData;
  heapErrorCode rspError;

  int           credits;                              // Sender side credit counter
  int           sentCount;
  int           cycleCount;
  int           testErrors;                           // Errors in the running test
  int           errorCount;
  int           testsPassed;
  int           testsFailed;
  integer       seed = 32'he0a9_3e46;
  heapData      expData  [$];                         // Expected responses in order
  heapErrorCode expError [$];

  `include "heapModel.svh"

  heapTop u_heapTop (
    .clock, .reset, .reqValid, .reqOp, .reqArray, .reqIndex, .reqData,
    .creditReturn, .rspValid, .rspData, .rspError
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;                          // 100 ns period

  //--------------------------------------------------------------------------
  // Compare tasks
  //--------------------------------------------------------------------------
  task automatic checkData(input heapData expected, input heapData actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t rspData expected %h got %h", $time, expected, actual);
      testErrors++;
    end
  endtask

  task automatic checkError(input heapErrorCode expected, input heapErrorCode actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t rspError expected %0d got %0d", $time, expected, actual);
      testErrors++;
    end
  endtask

  //--------------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------------
  task automatic sendRequest(input heapOp op, input arrayNum arr, input elemIndex idx,
                             input heapData data);
    heapData      predData;
    heapErrorCode predError;
    while (credits == 0) begin                        // Hold off until a credit is back
      reqValid = 1'b0;
      @(posedge clock);
      #1;
    end
    heapModel(op, arr, idx, data, predData, predError);
    expData.push_back(predData);
    expError.push_back(predError);
    reqValid = 1'b1;
    reqOp    = op;
    reqArray = arr;
    reqIndex = idx;
    reqData  = data;
    credits--;
    sentCount++;
    @(posedge clock);
    #1;
    reqValid = 1'b0;
  endtask

  // Waits for outstanding responses and then reports the test
  task automatic finishTest(input string name);
    int waited;
    waited = 0;
    while (expData.size() != 0 && waited < 50) begin
      @(posedge clock);
      waited++;
    end
    if (expData.size() != 0) begin
      $display("%s: %0d responses missing at end of test", name, expData.size());
      testErrors += expData.size();
      expData.delete();
      expError.delete();
    end
    if (testErrors == 0) begin
      $display("%-14s passed", name);
      testsPassed++;
    end else begin
      $display("%-14s failed with %0d errors", name, testErrors);
      testsFailed++;
    end
    errorCount += testErrors;
    testErrors = 0;
    @(posedge clock);
    #1;
  endtask

  //--------------------------------------------------------------------------
  // Response checker and credit return
  //--------------------------------------------------------------------------
  always @(negedge clock) begin
    if (!reset && rspValid) begin
      if (expData.size() == 0) begin
        $display("Response at %0t with no request outstanding", $time);
        testErrors++;
      end else begin
        checkData(expData.pop_front(), rspData);
        checkError(expError.pop_front(), rspError);
      end
    end
  end

  always @(negedge clock) begin
    if (!reset && creditReturn) begin
      credits++;
      if (credits > queueDepth) begin                 // More credits than were spent
        $display("Credit returned at %0t with no request outstanding", $time);
        testErrors++;
      end
    end
  end

  // Watchdog limit grows with each request sent
  initial begin
    cycleCount = 0;
    while (cycleCount <= 4 * sentCount + 100) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Run stopped by the watchdog after %0d cycles", cycleCount);
    $display("Test FAILED");
    $finish;
  end

  //--------------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------------
  initial begin
    heapOp    op;
    arrayNum  arr;
    elemIndex idx;
    heapData  data;
    reset       = 1'b1;
    reqValid    = 1'b0;
    reqOp       = opAlloc;
    reqArray    = '0;
    reqIndex    = '0;
    reqData     = '0;
    credits     = queueDepth;
    sentCount   = 0;
    testErrors  = 0;
    errorCount  = 0;
    testsPassed = 0;
    testsFailed = 0;
    modelReset();
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;

    // Pool fills from 0 upward and then runs out
    for (int i = 0; i < arrayCount + 1; i++) sendRequest(opAlloc, '0, '0, '0);
    for (int i = 0; i < arrayCount; i++) sendRequest(opSize, arrayNum'(i), '0, '0);
    finishTest("allocFour");

    sendRequest(opWrite, 2'd0, 2'd0, 12'h5a1);
    sendRequest(opRead, 2'd0, 2'd0, '0);
    sendRequest(opWrite, 2'd0, 2'd2, 12'h7c3);        // Size becomes 3
    sendRequest(opSize, 2'd0, '0, '0);
    sendRequest(opWrite, 2'd0, 2'd1, 12'h0f0);
    sendRequest(opRead, 2'd0, 2'd1, '0);
    sendRequest(opRead, 2'd0, 2'd2, '0);
    sendRequest(opRead, 2'd0, 2'd3, '0);              // At the size
    finishTest("writeRead");

    for (int i = 0; i < arrayLength; i++) sendRequest(opPush, 2'd1, '0, heapData'(12'h100 + i));
    sendRequest(opPush, 2'd1, '0, 12'hfff);           // One too many
    for (int i = 0; i <= arrayLength; i++) sendRequest(opPop, 2'd1, '0, '0);
    finishTest("pushPop");

    for (int i = 0; i < 3; i++) sendRequest(opPush, 2'd2, '0, heapData'(i));
    sendRequest(opUp, 2'd2, 2'd0, heapData'(99));
    sendRequest(opSize, 2'd2, '0, '0);
    for (int i = 0; i < arrayLength; i++) sendRequest(opRead, 2'd2, elemIndex'(i), '0);
    sendRequest(opDown, 2'd2, 2'd1, '0);
    for (int i = 0; i < 3; i++) sendRequest(opRead, 2'd2, elemIndex'(i), '0);
    sendRequest(opSize, 2'd2, '0, '0);
    finishTest("insertRemove");

    sendRequest(opFree, 2'd1, '0, '0);
    sendRequest(opFree, 2'd2, '0, '0);
    sendRequest(opFree, 2'd2, '0, '0);                // Double free
    sendRequest(opRead, 2'd1, 2'd0, '0);
    sendRequest(opPush, 2'd1, '0, 12'h321);
    sendRequest(opAlloc, '0, '0, '0);                 // Gets 2 back
    sendRequest(opAlloc, '0, '0, '0);
    sendRequest(opSize, 2'd2, '0, '0);                // Held 3 elements before the free
    sendRequest(opSize, 2'd1, '0, '0);
    finishTest("freeReuse");

    for (int n = 0; n < 80; n++) begin
      op   = heapOp'($unsigned($random(seed)) % 9);
      arr  = arrayNum'($random(seed));
      idx  = elemIndex'($random(seed));
      data = heapData'($random(seed));
      if (op == opWrite && modelSizes[arr] < arrayLength) begin
        // No gap below the index keeps every read on a written element
        idx = elemIndex'($unsigned($random(seed)) % (modelSizes[arr] + 1));
      end
      if (($random(seed) & 3) == 0) begin             // Occasional idle cycle
        @(posedge clock);
        #1;
      end
      sendRequest(op, arr, idx, data);
    end
    finishTest("randomMix");

    $display("Tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errorCount);
    if (testsFailed == 0 && errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
